//--- src/smc_mac_pkg.sv
/*
 * shared definitions for the multiple access controller
 * transfer size and state encodings, bus widths, access-count rule
 */
`default_nettype none

package smc_mac_pkg;

  localparam int DATA_W = 32; // host data width
  localparam int LANE_W = 8;  // external memory bus width

  // host transfer size, same codes as the ahb side
  typedef enum logic [1:0] {
    xsize_byte = 2'd0,
    xsize_half = 2'd1,
    xsize_word = 2'd2
  } xfer_size_t;

  typedef logic [1:0] access_cnt_t; // accesses left after the current one

  // controller states
  typedef enum logic [2:0] {
    st_idle        = 3'd0,
    st_mem_req     = 3'd1, // mem_req high, waiting for mem_ack
    st_mem_release = 3'd2, // mem_req low, waiting for mem_ack to drop
    st_host_ack    = 3'd3  // transfer done, waiting for host_req to drop
  } mac_state_t;

  // ----------------------------------------
  // number of byte accesses minus one
  // ----------------------------------------
  function automatic access_cnt_t num_accesses(input xfer_size_t size);
    case (size)
      xsize_half: return 2'd1; // two accesses
      xsize_word: return 2'd3; // four accesses
      default:    return 2'd0; // single byte, also the unused code
    endcase
  endfunction

endpackage

`default_nettype wire

//--- src/mac_ctrl_if.sv
/*
 * control interface between the controller FSM,
 * the access counter and the byte lane datapath
 */
`timescale 1ns/10ps
`default_nettype none

interface mac_ctrl_if;

  logic                     load;       // first cycle of a host transfer
  logic                     step;       // memory access completed
  logic                     latch;      // step on a read, store the byte
  smc_mac_pkg::xfer_size_t  xfer_size;  // registered transfer size
  smc_mac_pkg::access_cnt_t num_access; // accesses still to do
  logic                     last;       // current access is the final one

  modport fsm (
    output load, step, latch,
    input  last
  );

  modport counter (
    input  load, step,
    output xfer_size, num_access, last
  );

  modport datapath (
    input latch, xfer_size, num_access
  );

endinterface

`default_nettype wire

//--- src/mac_fsm.sv
/*
 * controller FSM
 * host and memory four-phase handshakes, memory address and write flag
 */
`timescale 1ns/10ps
`default_nettype none

module mac_fsm #(
  parameter int ADDR_W = 16
) (
  input  logic              sys_clk30,
  input  logic              n_sys_reset30,
  input  logic              host_req,
  input  logic              host_write,
  input  logic [ADDR_W-1:0] host_addr,
  input  logic              mem_ack,
  mac_ctrl_if.fsm           ctrl,
  output logic              host_ack,
  output logic              mem_req,
  output logic              mem_write,
  output logic [ADDR_W-1:0] mem_addr
);

  smc_mac_pkg::mac_state_t state;     // current state
  smc_mac_pkg::mac_state_t state_nxt; // next state
  logic                    final_acc; // last flag captured at the step

  // ----------------------------------------
  // handshake strobes to counter and datapath
  // ----------------------------------------
  assign ctrl.load  = (state == smc_mac_pkg::st_idle) && host_req;
  assign ctrl.step  = (state == smc_mac_pkg::st_mem_req) && mem_ack; // ack seen
  assign ctrl.latch = ctrl.step && !mem_write; // reads only

  assign mem_req  = (state == smc_mac_pkg::st_mem_req);
  assign host_ack = (state == smc_mac_pkg::st_host_ack);

  // ----------------------------------------
  // next state
  // ----------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      smc_mac_pkg::st_idle:
        if (host_req)
          state_nxt = smc_mac_pkg::st_mem_req;
      smc_mac_pkg::st_mem_req:
        if (mem_ack)
          state_nxt = smc_mac_pkg::st_mem_release; // drop mem_req
      smc_mac_pkg::st_mem_release:
        if (!mem_ack) // memory side back to rest
          state_nxt = final_acc ? smc_mac_pkg::st_host_ack : smc_mac_pkg::st_mem_req;
      smc_mac_pkg::st_host_ack:
        if (!host_req)
          state_nxt = smc_mac_pkg::st_idle;
      default:
        state_nxt = smc_mac_pkg::st_idle; // unused codes recover
    endcase
  end

  always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
  begin
    if (!n_sys_reset30)
    begin
      state     <= smc_mac_pkg::st_idle;
      final_acc <= 1'b0;
      mem_write <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (ctrl.load)
        mem_write <= host_write; // held for the whole transfer
      if (ctrl.step)
        final_acc <= ctrl.last;  // counter moves on at this edge
    end
  end

  // base address at start, next byte after each access
  always_ff @(posedge sys_clk30)
  begin
    if (ctrl.load)
      mem_addr <= host_addr;
    else if (ctrl.step)
      mem_addr <= mem_addr + 1'b1;
  end

endmodule

`default_nettype wire

//--- src/access_counter.sv
/*
 * access counter
 * transfer size register, remaining access count, last access flag
 */
`timescale 1ns/10ps
`default_nettype none

module access_counter (
  input  logic                    sys_clk30,
  input  logic                    n_sys_reset30,
  input  smc_mac_pkg::xfer_size_t host_size,
  mac_ctrl_if.counter             ctrl
);

  smc_mac_pkg::xfer_size_t  size_q; // size of the running transfer
  smc_mac_pkg::access_cnt_t cnt_q;  // accesses left after this one

  always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
  begin
    if (!n_sys_reset30)
    begin
      size_q <= smc_mac_pkg::xsize_byte;
      cnt_q  <= '0;
    end
    else if (ctrl.load)
    begin
      size_q <= host_size;
      cnt_q  <= smc_mac_pkg::num_accesses(host_size); // 0, 1 or 3
    end
    else if (ctrl.step)
      cnt_q <= cnt_q - 2'd1; // wraps after the final access
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  assign ctrl.xfer_size  = size_q;
  assign ctrl.num_access = cnt_q;
  assign ctrl.last       = (cnt_q == 2'd0); // final byte of the transfer

endmodule

`default_nettype wire

//--- src/byte_lane_datapath.sv
/*
 * byte lane datapath
 * write byte select onto the 8-bit bus, read byte assembly,
 * narrow read replication to the host word
 */
`timescale 1ns/10ps
`default_nettype none

module byte_lane_datapath (
  input  logic                            sys_clk30,
  input  logic                            n_sys_reset30,
  input  logic [smc_mac_pkg::DATA_W-1:0]  host_wdata,
  input  logic [smc_mac_pkg::LANE_W-1:0]  mem_rdata,
  mac_ctrl_if.datapath                    ctrl,
  output logic [smc_mac_pkg::LANE_W-1:0]  mem_wdata,
  output logic [smc_mac_pkg::DATA_W-1:0]  host_rdata
);

  localparam int LW = smc_mac_pkg::LANE_W;
  localparam int HW = 2 * smc_mac_pkg::LANE_W; // halfword width

  logic [smc_mac_pkg::DATA_W-1:0] rd_word; // assembled read data

  // ----------------------------------------
  // write steering, big-endian
  // ----------------------------------------
  // count 3 is the first access of a word, so the msb byte goes first
  always_comb
  begin
    case (ctrl.num_access)
      2'd3:    mem_wdata = host_wdata[4*LW-1:3*LW]; // bits 31:24
      2'd2:    mem_wdata = host_wdata[3*LW-1:2*LW]; // bits 23:16
      2'd1:    mem_wdata = host_wdata[2*LW-1:LW];   // bits 15:8
      default: mem_wdata = host_wdata[LW-1:0];      // bits 7:0, last access
    endcase
  end

  // ----------------------------------------
  // read assembly
  // ----------------------------------------
  always_ff @(posedge sys_clk30 or negedge n_sys_reset30)
  begin
    if (!n_sys_reset30)
      rd_word <= '0;
    else if (ctrl.latch)
    begin
      // lane picked by the count before it decrements
      case (ctrl.num_access)
        2'd3:    rd_word[4*LW-1:3*LW] <= mem_rdata;
        2'd2:    rd_word[3*LW-1:2*LW] <= mem_rdata;
        2'd1:    rd_word[2*LW-1:LW]   <= mem_rdata;
        default: rd_word[LW-1:0]      <= mem_rdata;
      endcase
    end
  end

  // narrow reads end in the low lanes, copy them up
  always_comb
  begin
    case (ctrl.xfer_size)
      smc_mac_pkg::xsize_word:
        host_rdata = rd_word;
      smc_mac_pkg::xsize_half:
        host_rdata = {2{rd_word[HW-1:0]}}; // both halves
      default:
        host_rdata = {4{rd_word[LW-1:0]}}; // byte in every lane
    endcase
  end

endmodule

`default_nettype wire

//--- src/smc_mac_top.sv
/*
 * multiple access controller top level
 * host and 8-bit memory ports, FSM, counter and datapath
 */
`timescale 1ns/10ps
`default_nettype none

module smc_mac_top #(
  parameter int ADDR_W = 16
) (
  input  logic                           sys_clk30,
  input  logic                           n_sys_reset30,
  // host side
  input  logic                           host_req,
  input  logic                           host_write,
  input  smc_mac_pkg::xfer_size_t        host_size,
  input  logic [ADDR_W-1:0]              host_addr,
  input  logic [smc_mac_pkg::DATA_W-1:0] host_wdata,
  output logic                           host_ack,
  output logic [smc_mac_pkg::DATA_W-1:0] host_rdata,
  // memory side
  output logic                           mem_req,
  output logic                           mem_write,
  output logic [ADDR_W-1:0]              mem_addr,
  output logic [smc_mac_pkg::LANE_W-1:0] mem_wdata,
  input  logic                           mem_ack,
  input  logic [smc_mac_pkg::LANE_W-1:0] mem_rdata
);

  mac_ctrl_if ctrl_if (); // load, step, latch and count status

  // ----------------------------------------
  // handshakes and address
  // ----------------------------------------
  mac_fsm #(
    .ADDR_W (ADDR_W)
  ) u_mac_fsm (
    .sys_clk30     (sys_clk30),
    .n_sys_reset30 (n_sys_reset30),
    .host_req      (host_req),
    .host_write    (host_write),
    .host_addr     (host_addr),
    .mem_ack       (mem_ack),
    .ctrl          (ctrl_if.fsm),
    .host_ack      (host_ack),
    .mem_req       (mem_req),
    .mem_write     (mem_write),
    .mem_addr      (mem_addr)
  );

  access_counter u_access_counter (
    .sys_clk30     (sys_clk30),
    .n_sys_reset30 (n_sys_reset30),
    .host_size     (host_size),
    .ctrl          (ctrl_if.counter)
  );

  // byte steering both ways
  byte_lane_datapath u_byte_lane_datapath (
    .sys_clk30     (sys_clk30),
    .n_sys_reset30 (n_sys_reset30),
    .host_wdata    (host_wdata),
    .mem_rdata     (mem_rdata),
    .ctrl          (ctrl_if.datapath),
    .mem_wdata     (mem_wdata),
    .host_rdata    (host_rdata)
  );

endmodule

`default_nettype wire

//--- test/smc_mac_checker.sv
/*
 * concurrent handshake assertions, bound to smc_mac_top
 */
`timescale 1ns/10ps
`default_nettype none

module smc_mac_checker #(
  parameter int ADDR_W = 16
) (
  input logic              sys_clk30,
  input logic              n_sys_reset30,
  input logic              host_req,
  input logic              host_ack,
  input logic              mem_req,
  input logic              mem_ack,
  input logic              mem_write,
  input logic [ADDR_W-1:0] mem_addr
);

  int fail_cnt = 0; // failed assertions so far

  // request held until the memory answers
  req_held_a: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
    mem_req && !mem_ack |=> mem_req)
  else
  begin
    $error("mem_req fell before mem_ack");
    fail_cnt++;
  end

  addr_stable_a: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
    mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_write))
  else
  begin
    $error("mem_addr or mem_write moved during a memory request");
    fail_cnt++;
  end

  no_overlap_a: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
    !(mem_req && host_ack))
  else
  begin
    $error("mem_req high while host_ack high");
    fail_cnt++;
  end

  // host side release order
  ack_release_a: assert property (@(posedge sys_clk30) disable iff (!n_sys_reset30)
    $fell(host_ack) |-> !$past(host_req))
  else
  begin
    $error("host_ack fell while host_req was still high");
    fail_cnt++;
  end

endmodule

`default_nettype wire

//--- test/sram_model.sv
/*
 * byte-wide memory model, 256 bytes
 * four-phase responder with a random 0 to 3 cycle delay, access counter
 */
`timescale 1ns/10ps
`default_nettype none

module sram_model #(
  parameter int ADDR_W = 16,
  parameter int SEED   = 0
) (
  input  logic                           sys_clk30,
  input  logic                           n_sys_reset30,
  input  logic                           mem_req,
  input  logic                           mem_write,
  input  logic [ADDR_W-1:0]              mem_addr,
  input  logic [smc_mac_pkg::LANE_W-1:0] mem_wdata,
  output logic                           mem_ack,
  output logic [smc_mac_pkg::LANE_W-1:0] mem_rdata,
  output int                             access_total // all accesses so far
);

  logic [smc_mac_pkg::LANE_W-1:0] mem [256];
  int unsigned                    delay;    // wait cycles before the ack

  initial
  begin
    mem_ack      = 1'b0;
    mem_rdata    = '0;
    access_total = 0;
    void'($urandom(SEED));
    for (int i = 0; i < 256; i++)
      mem[i] = 8'(i * 29 + 7); // odd multiplier gives every address its own byte
    forever
    begin
      @(posedge sys_clk30);
      #1; // look after the edge once outputs settle
      if (n_sys_reset30 && mem_req)
      begin
        delay = $urandom_range(3, 0);
        repeat (delay)
        begin
          @(posedge sys_clk30);
          #1;
        end
        if (mem_write)
          mem[mem_addr[7:0]] = mem_wdata;
        else
          mem_rdata = mem[mem_addr[7:0]]; // held past the ack
        access_total++;
        mem_ack = 1'b1;
        do
        begin
          @(posedge sys_clk30);
          #1;
        end
        while (mem_req); // wait for the release
        mem_ack = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- test/smc_mac_tb.sv
/*
 * testbench for the multiple access controller
 * clock, reset, directed and random host transfers, compare tasks, timeout
 */
`timescale 1ns/10ps
`default_nettype none

module smc_mac_tb;

  localparam int ADDR_W  = 16;
  localparam int DATA_W  = smc_mac_pkg::DATA_W;
  localparam int LANE_W  = smc_mac_pkg::LANE_W;
  localparam int SEED    = 32'h0e51c477;
  localparam int TIMEOUT = 20 * 4 * 12 + 10; // transfers x accesses x cycles plus reset

  logic                    sys_clk30;
  logic                    n_sys_reset30;
  logic                    host_req, host_write, host_ack;
  smc_mac_pkg::xfer_size_t host_size;
  logic [ADDR_W-1:0]       host_addr, mem_addr;
  logic [DATA_W-1:0]       host_wdata, host_rdata;
  logic                    mem_req, mem_write, mem_ack;
  logic [LANE_W-1:0]       mem_wdata, mem_rdata;
  logic [LANE_W-1:0]       model_mem [256]; // scoreboard image of the memory
  int                      access_total;
  int                      cycle_cnt = 0;

  smc_mac_top #(.ADDR_W(ADDR_W)) u_smc_mac_top (.*);
  sram_model #(.ADDR_W(ADDR_W), .SEED(SEED)) u_sram_model (.*);
  bind smc_mac_top smc_mac_checker #(.ADDR_W(ADDR_W)) u_smc_mac_checker (.*);

  always #50 sys_clk30 = ~sys_clk30; // 100 ns period

  always @(posedge sys_clk30)
  begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT)
    begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_cnt);
      stop_failed();
    end
  end

  always @(u_smc_mac_top.u_smc_mac_checker.fail_cnt)
  begin
    if (u_smc_mac_top.u_smc_mac_checker.fail_cnt != 0)
    begin
      $display("handshake assertion failed in the bound checker");
      stop_failed();
    end
  end

  // ----------------------------------------
  // compare and helper tasks
  // ----------------------------------------
  task automatic stop_failed();
    $display("Simulation FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] got, exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic check_count(input string name, input integer got, exp);
    if (got !== exp)
    begin
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_failed();
    end
  endtask

  task automatic next_cycle();
    @(posedge sys_clk30);
    #1; // drive and sample off the edge
  endtask

  function automatic int expected_accesses(input smc_mac_pkg::xfer_size_t size);
    case (size)
      smc_mac_pkg::xsize_half: return 2;
      smc_mac_pkg::xsize_word: return 4;
      default:                 return 1;
    endcase
  endfunction

  // big-endian so the lowest address holds the msb
  function automatic logic [DATA_W-1:0] model_word(input int a);
    return {model_mem[a], model_mem[a+1], model_mem[a+2], model_mem[a+3]};
  endfunction

  function automatic logic [DATA_W-1:0] sram_word(input int a);
    return {u_sram_model.mem[a], u_sram_model.mem[a+1],
            u_sram_model.mem[a+2], u_sram_model.mem[a+3]};
  endfunction

  function automatic logic [DATA_W-1:0] expected_read(input smc_mac_pkg::xfer_size_t size,
                                                      input int a);
    case (size)
      smc_mac_pkg::xsize_word: return model_word(a);
      smc_mac_pkg::xsize_half: return {2{model_mem[a], model_mem[a+1]}};
      default:                 return {4{model_mem[a]}}; // byte in every lane
    endcase
  endfunction

  // one four-phase host transfer with rdata taken while host_ack is high
  task automatic host_transfer(input logic wr, input smc_mac_pkg::xfer_size_t size,
                               input int a, input logic [DATA_W-1:0] wdata,
                               output logic [DATA_W-1:0] rdata);
    int start_total;
    start_total = access_total;
    next_cycle();
    host_req   = 1'b1;
    host_write = wr;
    host_size  = size;
    host_addr  = ADDR_W'(a);
    host_wdata = wdata;
    do
      next_cycle();
    while (!host_ack);
    rdata = host_rdata;
    check_count("access count", access_total - start_total, expected_accesses(size));
    host_req = 1'b0;
    do
      next_cycle();
    while (host_ack);
  endtask

  task automatic host_write_task(input smc_mac_pkg::xfer_size_t size, input int a,
                                 input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] unused;
    int                n;
    n = expected_accesses(size);
    host_transfer(1'b1, size, a, data, unused);
    for (int k = 0; k < n; k++)
      model_mem[a+k] = data[LANE_W*(n-1-k) +: LANE_W]; // msb byte first
    check_word("sram bytes", sram_word(a), model_word(a));
  endtask

  task automatic host_read_task(input smc_mac_pkg::xfer_size_t size, input int a,
                                output logic [DATA_W-1:0] data);
    host_transfer(1'b0, size, a, '0, data);
    check_word("host_rdata", data, expected_read(size, a));
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_reset();
    check_count("host_ack", host_ack, 0);
    check_count("mem_req", mem_req, 0);
  endtask

  task automatic test_byte();
    logic [DATA_W-1:0] rd;
    host_write_task(smc_mac_pkg::xsize_byte, 16, 32'h0000_005a);
    host_read_task(smc_mac_pkg::xsize_byte, 16, rd);
    check_word("host_rdata", rd, 32'h5a5a_5a5a);
  endtask

  task automatic test_half();
    logic [DATA_W-1:0] rd;
    host_write_task(smc_mac_pkg::xsize_half, 33, 32'h0000_c3e1);
    check_word("sram bytes", {16'h0, u_sram_model.mem[33], u_sram_model.mem[34]},
               32'h0000_c3e1); // 15:8 at base and 7:0 next
    host_read_task(smc_mac_pkg::xsize_half, 33, rd);
    check_word("host_rdata", rd, 32'hc3e1_c3e1);
  endtask

  task automatic test_word();
    logic [DATA_W-1:0] rd;
    host_write_task(smc_mac_pkg::xsize_word, 64, 32'h1234_abcd);
    check_word("sram bytes", sram_word(64), 32'h1234_abcd);
    host_read_task(smc_mac_pkg::xsize_word, 64, rd);
    check_word("host_rdata", rd, 32'h1234_abcd);
  endtask

  task automatic test_random();
    logic [DATA_W-1:0]       rd;
    smc_mac_pkg::xfer_size_t size;
    int                      a;
    repeat (12)
    begin
      size = smc_mac_pkg::xfer_size_t'($urandom_range(2, 0));
      a    = $urandom_range(252, 0); // room for a word
      if ($urandom_range(1, 0))
        host_write_task(size, a, $urandom);
      else
        host_read_task(size, a, rd);
    end
  endtask

  initial
  begin
    sys_clk30     = 1'b0;
    n_sys_reset30 = 1'b0;
    host_req      = 1'b0;
    host_write    = 1'b0;
    host_size     = smc_mac_pkg::xsize_byte;
    host_addr     = '0;
    host_wdata    = '0;
    void'($urandom(SEED));
    repeat (10)
      @(posedge sys_clk30);
    #1;
    n_sys_reset30 = 1'b1;
    for (int i = 0; i < 256; i++)
      model_mem[i] = u_sram_model.mem[i]; // start from the memory fill
    test_reset();
    test_byte();
    test_half();
    test_word();
    test_random();
    next_cycle(); // last host_ack release reaches the checker
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
src/smc_mac_pkg.sv
src/mac_ctrl_if.sv
src/mac_fsm.sv
src/access_counter.sv
src/byte_lane_datapath.sv
src/smc_mac_top.sv
test/smc_mac_checker.sv
test/sram_model.sv
test/smc_mac_tb.sv
